// ==== list.f ====
+incdir+dv
src/mipsPkg.sv
src/controlDecoder.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/hazardUnit.sv
src/mipsCore.sv
dv/coreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
SIM       := $(BUILD_DIR)/V$(TOP)

SOURCES := $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tbPrograms.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// all programs back to back and each one starting at address 0
// wbExp rows are {8'b dest reg, 32'b data} and storeExp rows {32'b addr, 32'b data}
localparam int NumTests = 5;

string testName [NumTests] = '{"alu", "forward", "loadstore", "branch", "jump"};
int progLen    [NumTests] = '{19, 5, 10, 15, 9};
int wbCount    [NumTests] = '{18, 5, 8, 8, 7};
int storeCount [NumTests] = '{0, 0, 2, 0, 0};

logic [31:0] progWords [58] = '{
    32'h24010005, 32'h2402FFFD, 32'h00221821, 32'h00222023, 32'h00222824, 32'h00223025,
    32'h00223826, 32'h00224027, 32'h0041482A, 32'h0041502B, 32'h00015900, 32'h00026043,
    32'h00026F02, 32'h3C0E1234, 32'h35CE5678, 32'h304FFF0F, 32'h3830FFFF, 32'h2851FFFE,
    32'h24200007,                                                         // addiu r0 is dropped
    32'h24010001, 32'h00211021, 32'h00411821, 32'h00612021, 32'h00822823,
    32'h24010040, 32'h24020077, 32'hAC220000, 32'hAC210004, 32'h8C230000, 32'h00632021,
    32'h8C250004, 32'h24060009, 32'h00A63821, 32'h8C080080,               // last load hits fill
    32'h24010003, 32'h24020003, 32'h10220003, 32'h24030001, 32'h24040001, 32'h24040002,
    32'h14220002, 32'h24050005, 32'h24060006, 32'h14200002, 32'h24070007, 32'h24080008,
    32'h10200001, 32'h24090009, 32'h240A000A,
    32'h0C000004, 32'h24010001, 32'h24020002, 32'h08000008, 32'h24030003, 32'h03E00008,
    32'h24040004, 32'h24050005, 32'h24060006
};

logic [39:0] wbExp [46] = '{
    40'h01_00000005, 40'h02_FFFFFFFD, 40'h03_00000002, 40'h04_00000008, 40'h05_00000005,
    40'h06_FFFFFFFD, 40'h07_FFFFFFF8, 40'h08_00000002, 40'h09_00000001, 40'h0A_00000000,
    40'h0B_00000050, 40'h0C_FFFFFFFE, 40'h0D_0000000F, 40'h0E_12340000, 40'h0E_12345678,
    40'h0F_0000FF0D, 40'h10_0000FFFA, 40'h11_00000001,
    40'h01_00000001, 40'h02_00000002, 40'h03_00000003, 40'h04_00000004, 40'h05_00000002,
    40'h01_00000040, 40'h02_00000077, 40'h03_00000077, 40'h04_000000EE, 40'h05_00000040,
    40'h06_00000009, 40'h07_00000049, 40'h08_5A5A5ADA,
    40'h01_00000003, 40'h02_00000003, 40'h03_00000001, 40'h05_00000005, 40'h06_00000006,
    40'h07_00000007, 40'h09_00000009, 40'h0A_0000000A,
    40'h1F_00000008, 40'h01_00000001, 40'h03_00000003, 40'h04_00000004, 40'h02_00000002,
    40'h03_00000003, 40'h06_00000006
};

// pc of each expected writeback in wbExp order
logic [31:0] wbPcExp [46] = '{
    32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h1C, 32'h20,
    32'h24, 32'h28, 32'h2C, 32'h30, 32'h34, 32'h38, 32'h3C, 32'h40, 32'h44,
    32'h00, 32'h04, 32'h08, 32'h0C, 32'h10,
    32'h00, 32'h04, 32'h10, 32'h14, 32'h18, 32'h1C, 32'h20, 32'h24,
    32'h00, 32'h04, 32'h0C, 32'h1C, 32'h20, 32'h28, 32'h34, 32'h38,
    32'h00, 32'h04, 32'h10, 32'h18, 32'h08, 32'h10, 32'h20
};

logic [63:0] storeExp [2] = '{64'h00000040_00000077, 64'h00000044_00000040};

`endif

// ==== dv/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;

    localparam int          ImemWords    = 64;
    localparam int          DmemWords    = 64;
    localparam int          EventTimeout = 400; // cycles per wait
    localparam logic [31:0] ResetPc      = 32'h0000_0000;

    logic        clk, arstN;
    logic [31:0] imemData, dmemRdata, rdPend;
    logic [31:0] imemAddr, dmemAddr, dmemWdata, wbPc, wbData;
    logic        dmemEn, dmemWe, wbEn;
    logic [4:0]  wbReg;

    logic [31:0] imem [ImemWords];
    logic [31:0] dmem [DmemWords];
    logic [4:0]  wbRegQ [$];
    logic [31:0] wbPcQ [$];
    logic [31:0] wbDataQ [$];
    logic [63:0] storeQ [$];
    int          errors, failedTests, checks;

    `include "tbPrograms.svh"

    mipsCore #(.ResetPc(ResetPc)) DUT (
        .clk_i       (clk),
        .arstN_i     (arstN),
        .imemData_i  (imemData),
        .dmemRdata_i (dmemRdata),
        .imemAddr_o  (imemAddr),
        .dmemEn_o    (dmemEn),
        .dmemWe_o    (dmemWe),
        .dmemAddr_o  (dmemAddr),
        .dmemWdata_o (dmemWdata),
        .wbEn_o      (wbEn),
        .wbPc_o      (wbPc),
        .wbReg_o     (wbReg),
        .wbData_o    (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // untouched data words depend on their full address
    function automatic logic [31:0] fillWord(input int idx);
        return (32'(idx) << 2) ^ 32'h5A5A_5A5A;
    endfunction

    // inputs change on the falling edge only
    always @(negedge clk) begin
        imemData  = (imemAddr < 32'(ImemWords * 4)) ? imem[imemAddr[7:2]] : 32'h0;
        dmemRdata = rdPend;
    end

    // memory model and event capture on the values just before the edge
    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < DmemWords; i++) begin
                dmem[i] = fillWord(i);
            end
            rdPend = '0;
            wbRegQ.delete();
            wbPcQ.delete();
            wbDataQ.delete();
            storeQ.delete();
        end else begin
            if (wbEn) begin
                wbRegQ.push_back(wbReg);
                wbPcQ.push_back(wbPc);
                wbDataQ.push_back(wbData);
            end
            if (dmemEn && dmemWe) begin
                dmem[dmemAddr[7:2]] = dmemWdata;
                storeQ.push_back({dmemAddr, dmemWdata});
            end else if (dmemEn) begin
                rdPend = dmem[dmemAddr[7:2]]; // seen by writeback next cycle
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic runTest(input int t);
        int wOff, eOff, sOff, cycles, errBefore;
        wOff = 0;
        eOff = 0;
        sOff = 0;
        for (int k = 0; k < t; k++) begin
            wOff += progLen[k];
            eOff += wbCount[k];
            sOff += storeCount[k];
        end
        errBefore = errors;

        @(negedge clk);
        arstN = 1'b0;
        for (int i = 0; i < ImemWords; i++) begin
            imem[i] = (i < progLen[t]) ? progWords[wOff + i] : 32'h0;
        end
        repeat (16) @(negedge clk);

        // outputs at rest while reset is held
        checkValue("imemAddr_o", imemAddr, ResetPc);
        checkValue("wbEn_o", 32'(wbEn), 32'h0);
        checkValue("dmemEn_o", 32'(dmemEn), 32'h0);
        checkValue("dmemWe_o", 32'(dmemWe), 32'h0);
        arstN = 1'b1;

        cycles = 0;
        while (wbRegQ.size() < wbCount[t] && cycles < EventTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (wbRegQ.size() < wbCount[t]) begin
            $display("test %0d timed out waiting for writebacks, saw %0d of %0d",
                     t, wbRegQ.size(), wbCount[t]);
            errors++;
        end
        cycles = 0;
        while (storeQ.size() < storeCount[t] && cycles < EventTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (storeQ.size() < storeCount[t]) begin
            $display("test %0d timed out waiting for stores, saw %0d of %0d",
                     t, storeQ.size(), storeCount[t]);
            errors++;
        end

        repeat (8) @(negedge clk); // let stray events show up
        if (wbRegQ.size() > wbCount[t] || storeQ.size() > storeCount[t]) begin
            $display("test %0d produced more writebacks or stores than expected", t);
            errors++;
        end

        for (int i = 0; i < wbCount[t] && i < wbRegQ.size(); i++) begin
            checkValue("wbReg_o", 32'(wbRegQ[i]), 32'(wbExp[eOff + i][39:32]));
            checkValue("wbPc_o", wbPcQ[i], wbPcExp[eOff + i]);
            checkValue("wbData_o", wbDataQ[i], wbExp[eOff + i][31:0]);
        end
        for (int i = 0; i < storeCount[t] && i < storeQ.size(); i++) begin
            checkValue("dmemAddr_o", storeQ[i][63:32], storeExp[sOff + i][63:32]);
            checkValue("dmemWdata_o", storeQ[i][31:0], storeExp[sOff + i][31:0]);
        end

        if (errors == errBefore) begin
            $display("test %0d %s: ok", t, testName[t]);
        end else begin
            $display("test %0d %s: failed with %0d errors", t, testName[t], errors - errBefore);
            failedTests++;
        end
    endtask

    initial begin
        arstN       = 1'b0;
        imemData    = '0;
        dmemRdata   = '0;
        errors      = 0;
        failedTests = 0;
        checks      = 0;
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NumTests, failedTests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  wire logic        clk_i,
    input  wire logic        arstN_i,
    input  wire logic [31:0] imemData_i,
    input  wire logic [31:0] dmemRdata_i,
    output logic      [31:0] imemAddr_o,
    output logic             dmemEn_o,
    output logic             dmemWe_o,
    output logic      [31:0] dmemAddr_o,
    output logic      [31:0] dmemWdata_o,
    // writeback trace, also the register file write port
    output logic             wbEn_o,
    output logic      [31:0] wbPc_o,
    output logic      [4:0]  wbReg_o,
    output logic      [31:0] wbData_o
);

    logic [31:0]     rdA, rdB, memResult;
    logic [4:0]      rsAddr, rtAddr, exDest, memDest;
    logic            exRegWrite, exMemRead, memRegWrite, memMemRead;
    logic            stallD;
    mipsPkg::fwdSelE fwdA, fwdB;
    mipsPkg::idExT   idEx;
    mipsPkg::exMemT  exMem;

    decodeStage #(.ResetPc(ResetPc)) decode (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .instr_i     (imemData_i),
        .stall_i     (stallD),
        .rdA_i       (rdA),
        .rdB_i       (rdB),
        .fwdA_i      (fwdA),
        .fwdB_i      (fwdB),
        .exResult_i  (exMem.aluResult),
        .memResult_i (memResult),
        .wbResult_i  (wbData_o),
        .pc_o        (imemAddr_o),
        .rsAddr_o    (rsAddr),
        .rtAddr_o    (rtAddr),
        .idEx_o      (idEx)
    );

    regFile rf (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .we_i     (wbEn_o),
        .waddr_i  (wbReg_o),
        .wdata_i  (wbData_o),
        .raddrA_i (rsAddr),
        .raddrB_i (rtAddr),
        .rdataA_o (rdA),
        .rdataB_o (rdB)
    );

    executeStage execute (
        .clk_i        (clk_i),
        .arstN_i      (arstN_i),
        .idEx_i       (idEx),
        .exMem_o      (exMem),
        .exDest_o     (exDest),
        .exRegWrite_o (exRegWrite),
        .exMemRead_o  (exMemRead)
    );

    memWbStage memWb (
        .clk_i         (clk_i),
        .arstN_i       (arstN_i),
        .exMem_i       (exMem),
        .dmemRdata_i   (dmemRdata_i),
        .dmemEn_o      (dmemEn_o),
        .dmemWe_o      (dmemWe_o),
        .dmemAddr_o    (dmemAddr_o),
        .dmemWdata_o   (dmemWdata_o),
        .memResult_o   (memResult),
        .memDest_o     (memDest),
        .memRegWrite_o (memRegWrite),
        .memMemRead_o  (memMemRead),
        .wbEn_o        (wbEn_o),
        .wbPc_o        (wbPc_o),
        .wbReg_o       (wbReg_o),
        .wbData_o      (wbData_o)
    );

    hazardUnit hazard (
        .rsAddr_i      (rsAddr),
        .rtAddr_i      (rtAddr),
        .exDest_i      (exDest),
        .exRegWrite_i  (exRegWrite),
        .exMemRead_i   (exMemRead),
        .memDest_i     (memDest),
        .memRegWrite_i (memRegWrite),
        .memMemRead_i  (memMemRead),
        .wbDest_i      (wbReg_o),
        .wbRegWrite_i  (wbEn_o),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB),
        .stall_o       (stallD)
    );

endmodule

`default_nettype wire

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire logic [4:0] rsAddr_i,
    input  wire logic [4:0] rtAddr_i,
    input  wire logic [4:0] exDest_i,
    input  wire logic       exRegWrite_i,
    input  wire logic       exMemRead_i,
    input  wire logic [4:0] memDest_i,
    input  wire logic       memRegWrite_i,
    input  wire logic       memMemRead_i,
    input  wire logic [4:0] wbDest_i,
    input  wire logic       wbRegWrite_i,
    output mipsPkg::fwdSelE fwdA_o,
    output mipsPkg::fwdSelE fwdB_o,
    output logic            stall_o
);

    // youngest producer wins
    function automatic mipsPkg::fwdSelE pickSource(input logic [4:0] src);
        if (src == '0) pickSource = mipsPkg::REGFILE;
        else if (exRegWrite_i && exDest_i == src) pickSource = mipsPkg::FROM_EX;
        else if (memRegWrite_i && memDest_i == src) pickSource = mipsPkg::FROM_MEM;
        else if (wbRegWrite_i && wbDest_i == src) pickSource = mipsPkg::FROM_WB;
        else pickSource = mipsPkg::REGFILE;
    endfunction

    // load data exists only once the load reaches writeback
    function automatic logic loadPending(input logic [4:0] src);
        loadPending = (src != '0) && ((exMemRead_i && exDest_i == src) ||
                                      (memMemRead_i && memDest_i == src));
    endfunction

    assign fwdA_o  = pickSource(rsAddr_i);
    assign fwdB_o  = pickSource(rtAddr_i);
    assign stall_o = loadPending(rsAddr_i) || loadPending(rtAddr_i);

endmodule

`default_nettype wire

// ==== src/memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire logic           clk_i,
    input  wire logic           arstN_i,
    input  wire mipsPkg::exMemT exMem_i,
    input  wire logic [31:0]    dmemRdata_i,
    output logic                dmemEn_o,
    output logic                dmemWe_o,
    output logic      [31:0]    dmemAddr_o,
    output logic      [31:0]    dmemWdata_o,
    output logic      [31:0]    memResult_o,
    output logic      [4:0]     memDest_o,
    output logic                memRegWrite_o,
    output logic                memMemRead_o,
    output logic                wbEn_o,
    output logic      [31:0]    wbPc_o,
    output logic      [4:0]     wbReg_o,
    output logic      [31:0]    wbData_o
);

    mipsPkg::exMemT exMemQ;
    mipsPkg::memWbT memWbQ;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            exMemQ <= '0;
            memWbQ <= '0;
        end else begin
            exMemQ           <= exMem_i;
            memWbQ.regWrite  <= exMemQ.regWrite && exMemQ.dest != '0; // r0 never written
            memWbQ.memRead   <= exMemQ.memRead;
            memWbQ.pc        <= exMemQ.pc;
            memWbQ.result    <= exMemQ.aluResult;
            memWbQ.dest      <= exMemQ.dest;
        end
    end

    // data memory answers in the following cycle
    assign dmemEn_o    = exMemQ.memRead | exMemQ.memWrite;
    assign dmemWe_o    = exMemQ.memWrite;
    assign dmemAddr_o  = exMemQ.aluResult;
    assign dmemWdata_o = exMemQ.storeData;

    assign memResult_o   = exMemQ.aluResult;
    assign memDest_o     = exMemQ.dest;
    assign memRegWrite_o = exMemQ.regWrite;
    assign memMemRead_o  = exMemQ.memRead;

    assign wbEn_o   = memWbQ.regWrite;
    assign wbPc_o   = memWbQ.pc;
    assign wbReg_o  = memWbQ.dest;
    assign wbData_o = memWbQ.memRead ? dmemRdata_i : memWbQ.result;

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic          clk_i,
    input  wire logic          arstN_i,
    input  wire mipsPkg::idExT idEx_i,
    output mipsPkg::exMemT     exMem_o,
    output logic      [4:0]    exDest_o,
    output logic               exRegWrite_o,
    output logic               exMemRead_o
);

    mipsPkg::idExT idExQ;
    logic [31:0]   aluOut;
    logic [4:0]    shAmt;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            idExQ <= '0;
        end else begin
            idExQ <= idEx_i;
        end
    end

    assign shAmt = idExQ.ctrl.useShamt ? idExQ.shamt : idExQ.opA[4:0];

    always_comb begin
        case (idExQ.ctrl.aluOp)
            mipsPkg::SUB:  aluOut = idExQ.opA - idExQ.opB;
            mipsPkg::AND:  aluOut = idExQ.opA & idExQ.opB;
            mipsPkg::OR:   aluOut = idExQ.opA | idExQ.opB;
            mipsPkg::XOR:  aluOut = idExQ.opA ^ idExQ.opB;
            mipsPkg::NOR:  aluOut = ~(idExQ.opA | idExQ.opB);
            mipsPkg::SLT:  aluOut = {31'b0, $signed(idExQ.opA) < $signed(idExQ.opB)};
            mipsPkg::SLTU: aluOut = {31'b0, idExQ.opA < idExQ.opB};
            mipsPkg::SLL:  aluOut = idExQ.opB << shAmt; // shifts act on rt
            mipsPkg::SRL:  aluOut = idExQ.opB >> shAmt;
            mipsPkg::SRA:  aluOut = $signed(idExQ.opB) >>> shAmt;
            mipsPkg::LUI:  aluOut = {idExQ.opB[15:0], 16'h0};
            default:       aluOut = idExQ.opA + idExQ.opB;
        endcase
    end

    always_comb begin
        exMem_o.regWrite  = idExQ.ctrl.regWrite;
        exMem_o.memRead   = idExQ.ctrl.memRead;
        exMem_o.memWrite  = idExQ.ctrl.memWrite;
        exMem_o.pc        = idExQ.pc;
        exMem_o.aluResult = idExQ.ctrl.isLink ? idExQ.opA : aluOut; // link address as is
        exMem_o.storeData = idExQ.storeData;
        exMem_o.dest      = idExQ.dest;
    end

    assign exDest_o     = idExQ.dest;
    assign exRegWrite_o = idExQ.ctrl.regWrite;
    assign exMemRead_o  = idExQ.ctrl.memRead;

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  wire logic            clk_i,
    input  wire logic            arstN_i,
    input  wire logic [31:0]     instr_i,
    input  wire logic            stall_i,
    input  wire logic [31:0]     rdA_i,
    input  wire logic [31:0]     rdB_i,
    input  wire mipsPkg::fwdSelE fwdA_i,
    input  wire mipsPkg::fwdSelE fwdB_i,
    input  wire logic [31:0]     exResult_i,
    input  wire logic [31:0]     memResult_i,
    input  wire logic [31:0]     wbResult_i,
    output logic      [31:0]     pc_o,
    output logic      [4:0]      rsAddr_o,
    output logic      [4:0]      rtAddr_o,
    output mipsPkg::idExT        idEx_o
);

    logic [31:0]   pcQ;     // fetch address
    logic [31:0]   pcDQ;    // pc of the word in decode
    logic [31:0]   instrQ;
    logic [31:0]   pcNext, pcPlus4, brTarget, jTarget;
    logic [31:0]   opRs, opRt, immExt;
    logic [4:0]    destReg;
    logic          takeBranch;
    mipsPkg::ctrlT ctrl;

    function automatic logic [31:0] fwdMux(input mipsPkg::fwdSelE sel, input logic [31:0] rf);
        case (sel)
            mipsPkg::FROM_EX:  fwdMux = exResult_i;
            mipsPkg::FROM_MEM: fwdMux = memResult_i;
            mipsPkg::FROM_WB:  fwdMux = wbResult_i;
            default:           fwdMux = rf;
        endcase
    endfunction

    controlDecoder ctrlDec (
        .instr_i    (instrQ),
        .ctrl_o     (ctrl),
        .destReg_o  (destReg)
    );

    // pc and fetched word hold while a load result is pending
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pcQ    <= ResetPc;
            instrQ <= '0; // sll r0 is a nop
        end else if (!stall_i) begin
            pcQ    <= pcNext;
            instrQ <= instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pcDQ <= pcQ;
        end
    end

    assign pc_o     = pcQ;
    assign rsAddr_o = instrQ[25:21];
    assign rtAddr_o = instrQ[20:16];

    assign opRs   = fwdMux(fwdA_i, rdA_i);
    assign opRt   = fwdMux(fwdB_i, rdB_i);
    assign immExt = ctrl.signExt ? {{16{instrQ[15]}}, instrQ[15:0]} : {16'h0, instrQ[15:0]};

    assign pcPlus4    = pcDQ + mipsPkg::PcStep;
    assign brTarget   = pcPlus4 + {immExt[29:0], 2'b00};
    assign jTarget    = {pcPlus4[31:28], instrQ[25:0], 2'b00};
    assign takeBranch = ctrl.isBranch & ((opRs == opRt) ^ ctrl.branchNe);

    // the word fetched now is the delay slot, so redirect the one after it
    always_comb begin
        if (takeBranch) begin
            pcNext = brTarget;
        end else if (ctrl.isJr) begin
            pcNext = opRs;
        end else if (ctrl.isJump) begin
            pcNext = jTarget;
        end else begin
            pcNext = pcQ + mipsPkg::PcStep;
        end
    end

    always_comb begin
        idEx_o.ctrl = ctrl;
        if (stall_i) begin // bubble into execute
            idEx_o.ctrl.regWrite = 1'b0;
            idEx_o.ctrl.memRead  = 1'b0;
            idEx_o.ctrl.memWrite = 1'b0;
        end
        idEx_o.pc        = pcDQ;
        idEx_o.opA       = ctrl.isLink ? pcPlus4 + mipsPkg::PcStep : opRs; // return address
        idEx_o.opB       = ctrl.useImm ? immExt : opRt;
        idEx_o.storeData = opRt;
        idEx_o.shamt     = instrQ[10:6];
        idEx_o.dest      = destReg;
    end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic        clk_i,
    input  wire logic        arstN_i,
    input  wire logic        we_i,
    input  wire logic [4:0]  waddr_i,
    input  wire logic [31:0] wdata_i,
    input  wire logic [4:0]  raddrA_i,
    input  wire logic [4:0]  raddrB_i,
    output logic      [31:0] rdataA_o,
    output logic      [31:0] rdataB_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write shows through to the readers
    assign rdataA_o = (raddrA_i == '0) ? '0 :
                      (we_i && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 :
                      (we_i && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

`default_nettype wire

// ==== src/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  wire logic [31:0] instr_i,
    output mipsPkg::ctrlT    ctrl_o,
    output logic      [4:0]  destReg_o
);

    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;

    assign opcode = mipsPkg::opcodeE'(instr_i[31:26]);
    assign funct  = mipsPkg::functE'(instr_i[5:0]);

    always_comb begin
        ctrl_o       = '0; // anything unknown stays a nop
        ctrl_o.aluOp = mipsPkg::ADD;
        case (opcode)
            mipsPkg::OP_SPECIAL: begin
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    mipsPkg::FN_ADDU: ctrl_o.aluOp = mipsPkg::ADD;
                    mipsPkg::FN_SUBU: ctrl_o.aluOp = mipsPkg::SUB;
                    mipsPkg::FN_AND:  ctrl_o.aluOp = mipsPkg::AND;
                    mipsPkg::FN_OR:   ctrl_o.aluOp = mipsPkg::OR;
                    mipsPkg::FN_XOR:  ctrl_o.aluOp = mipsPkg::XOR;
                    mipsPkg::FN_NOR:  ctrl_o.aluOp = mipsPkg::NOR;
                    mipsPkg::FN_SLT:  ctrl_o.aluOp = mipsPkg::SLT;
                    mipsPkg::FN_SLTU: ctrl_o.aluOp = mipsPkg::SLTU;
                    mipsPkg::FN_SLL: begin
                        ctrl_o.aluOp    = mipsPkg::SLL;
                        ctrl_o.useShamt = 1'b1;
                    end
                    mipsPkg::FN_SRL: begin
                        ctrl_o.aluOp    = mipsPkg::SRL;
                        ctrl_o.useShamt = 1'b1;
                    end
                    mipsPkg::FN_SRA: begin
                        ctrl_o.aluOp    = mipsPkg::SRA;
                        ctrl_o.useShamt = 1'b1;
                    end
                    mipsPkg::FN_JR: begin
                        ctrl_o.regWrite = 1'b0;
                        ctrl_o.isJr     = 1'b1;
                    end
                    default: ctrl_o.regWrite = 1'b0;
                endcase
            end
            mipsPkg::OP_J: ctrl_o.isJump = 1'b1;
            mipsPkg::OP_JAL: begin
                ctrl_o.isJump   = 1'b1;
                ctrl_o.isLink   = 1'b1;
                ctrl_o.regWrite = 1'b1;
            end
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                ctrl_o.isBranch = 1'b1;
                ctrl_o.signExt  = 1'b1; // branch offset
                ctrl_o.branchNe = (opcode == mipsPkg::OP_BNE);
            end
            mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.signExt  = 1'b1;
                ctrl_o.aluOp    = (opcode == mipsPkg::OP_SLTI) ? mipsPkg::SLT : mipsPkg::ADD;
            end
            mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.useImm   = 1'b1; // zero extended
                case (opcode)
                    mipsPkg::OP_ANDI: ctrl_o.aluOp = mipsPkg::AND;
                    mipsPkg::OP_ORI:  ctrl_o.aluOp = mipsPkg::OR;
                    mipsPkg::OP_XORI: ctrl_o.aluOp = mipsPkg::XOR;
                    default:          ctrl_o.aluOp = mipsPkg::LUI;
                endcase
            end
            mipsPkg::OP_LW, mipsPkg::OP_SW: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.signExt  = 1'b1;
                ctrl_o.regWrite = (opcode == mipsPkg::OP_LW);
                ctrl_o.memRead  = (opcode == mipsPkg::OP_LW);
                ctrl_o.memWrite = (opcode == mipsPkg::OP_SW);
            end
            default: ;
        endcase

        // rd for R-type, rt for immediates, ra for jal
        if (ctrl_o.isLink) begin
            destReg_o = mipsPkg::LinkReg;
        end else if (opcode == mipsPkg::OP_SPECIAL) begin
            destReg_o = instr_i[15:11];
        end else begin
            destReg_o = instr_i[20:16];
        end
    end

endmodule

`default_nettype wire

// ==== src/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } functE;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA, LUI
    } aluOpE;

    // where a decode operand comes from
    typedef enum logic [1:0] {
        REGFILE, FROM_EX, FROM_MEM, FROM_WB
    } fwdSelE;

    localparam logic [4:0]  LinkReg = 5'd31;
    localparam logic [31:0] PcStep  = 32'd4;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  useImm;   // operand b is the extended immediate
        logic  signExt;
        logic  useShamt; // shift by instr[10:6]
        logic  isBranch;
        logic  branchNe;
        logic  isJump;
        logic  isJr;
        logic  isLink;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] pc;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] storeData;
        logic [4:0]  shamt;
        logic [4:0]  dest;
    } idExT;

    typedef struct packed {
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic [31:0] pc;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  dest;
    } exMemT;

    typedef struct packed {
        logic        regWrite;
        logic        memRead;
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dest;
    } memWbT;

endpackage

`default_nettype wire
